// File: Bender.yml
package:
  name: cop_fu

sources:
  - src/cop_pkg.sv
  - src/cop_idecode.sv
  - src/cop_cprs.sv
  - src/cop_palu.sv
  - src/cop_rng.sv
  - src/cop_mem.sv
  - src/cop_fu_ctrl.sv
  - src/cop_fu_top.sv
  - target: test
    files:
      - test/tb_cop_fu.sv

// File: flist.f
src/cop_pkg.sv
src/cop_idecode.sv
src/cop_cprs.sv
src/cop_palu.sv
src/cop_rng.sv
src/cop_mem.sv
src/cop_fu_ctrl.sv
src/cop_fu_top.sv
test/tb_cop_fu.sv

// File: src/cop_cprs.sv
/*
  Crypto register file: sixteen 32-bit flops, cleared on reset.
  Two asynchronous read ports feed the units, one write port is
  driven by the writeback merge in the control block.
*/
`timescale 1ns/10ps
`default_nettype none

module cop_cprs (
    input  logic        g_clk,     // Clock
    input  logic        rst_n,     // Sync reset, active low
    input  logic [3:0]  rs1_addr,  // Read port 1 address
    output logic [31:0] rs1_rdata, // Read port 1 data
    input  logic [3:0]  rs2_addr,  // Read port 2 address
    output logic [31:0] rs2_rdata, // Read port 2 data
    input  logic        rd_wen,    // Write enable
    input  logic [3:0]  rd_addr,   // Write address
    input  logic [31:0] rd_wdata   // Write data
);

    import cop_pkg::*;

    logic [31:0] regs [COP_NUM_CPRS]; // Register storage

    assign rs1_rdata = regs[rs1_addr];
    assign rs2_rdata = regs[rs2_addr];

    always_ff @(posedge g_clk) begin
        if (!rst_n) begin
            for (int i = 0; i < COP_NUM_CPRS; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wen) begin
            regs[rd_addr] <= rd_wdata;
        end
    end

endmodule

`default_nettype wire

// File: src/cop_fu_ctrl.sv
/*
  Control for the crypto functional unit.
  Dispatches the held request to one unit by class, raises the response
  when that unit is done or the instruction is illegal, merges the unit
  CPR writes and forms the GPR writeback and result code.
*/
`timescale 1ns/10ps
`default_nettype none

module cop_fu_ctrl (
    input  logic                 cpu_insn_req,   // CPU request held
    input  cop_pkg::cop_class_e  id_class,       // Decoded class
    input  cop_pkg::cop_op_e     id_op,          // Decoded opcode
    input  logic [3:0]           id_crd,         // CPR destination
    input  logic [4:0]           id_rd,          // GPR destination
    input  logic                 id_illegal,     // Illegal instruction
    input  logic                 palu_idone,     // PALU done
    input  logic                 palu_cpr_wen,   // PALU CPR write
    input  logic [31:0]          palu_cpr_wdata, // PALU CPR data
    input  logic [31:0]          palu_gpr_wdata, // XCR2GPR result
    input  logic                 rng_idone,      // RNG done
    input  logic                 rng_cpr_wen,    // RNG CPR write
    input  logic [31:0]          rng_cpr_wdata,  // RNG CPR data
    input  logic                 mem_idone,      // Load/store done
    input  logic                 mem_cpr_wen,    // Load CPR write
    input  logic [31:0]          mem_cpr_wdata,  // Load CPR data
    input  logic                 mem_is_store,   // Store, not load
    input  logic                 mem_addr_error, // Misaligned
    input  logic                 mem_bus_error,  // Bus error
    output logic                 palu_ivalid,    // Dispatch to PALU
    output logic                 rng_ivalid,     // Dispatch to RNG
    output logic                 mem_ivalid,     // Dispatch to load/store
    output logic                 crd_wen,        // CPR write enable
    output logic [3:0]           crd_addr,       // CPR write address
    output logic [31:0]          crd_wdata,      // CPR write data
    output logic                 cop_insn_rsp,   // Instruction finished
    output logic                 cop_insn_ack,   // Request accepted
    output logic                 cop_wen,        // GPR write enable
    output logic [4:0]           cop_waddr,      // GPR write address
    output logic [31:0]          cop_wdata,      // GPR write data
    output cop_pkg::cop_result_e cop_result      // Result code
);

    import cop_pkg::*;

    logic insn_valid; // Legal request present

    assign insn_valid  = cpu_insn_req && !id_illegal;
    assign palu_ivalid = insn_valid && (id_class == CLASS_PALU || id_class == CLASS_MOVE);
    assign rng_ivalid  = insn_valid && (id_class == CLASS_RNG);
    assign mem_ivalid  = insn_valid && (id_class == CLASS_MEM);

    assign cop_insn_rsp = cpu_insn_req &&
                          (palu_idone || rng_idone || mem_idone || id_illegal);
    assign cop_insn_ack = cop_insn_rsp;

    // Idle units drive zero so OR is enough
    assign crd_wen   = cop_insn_rsp && (palu_cpr_wen || rng_cpr_wen || mem_cpr_wen);
    assign crd_addr  = id_crd;
    assign crd_wdata = palu_cpr_wdata | rng_cpr_wdata | mem_cpr_wdata;

    assign cop_wen   = cop_insn_rsp && !id_illegal && (id_op == OP_XCR2GPR);
    assign cop_waddr = id_rd;
    assign cop_wdata = palu_gpr_wdata;

    always_comb begin
        if (id_illegal)          cop_result = RES_BAD_INS;
        else if (mem_addr_error) cop_result = mem_is_store ? RES_BAD_SAD : RES_BAD_LAD;
        else if (mem_bus_error)  cop_result = mem_is_store ? RES_ST_ERR  : RES_LD_ERR;
        else                     cop_result = RES_SUCCESS;
    end

endmodule

`default_nettype wire

// File: src/cop_fu_top.sv
/*
  Top level of the crypto ISE functional unit.
  Sits beside the CPU and answers a held request combinationally, or
  after the memory access for aligned loads and stores.
*/
`timescale 1ns/10ps
`default_nettype none

module cop_fu_top (
    input  logic                 g_clk,         // Clock
    input  logic                 rst_n,         // Sync reset, active low
    input  logic                 cpu_insn_req,  // Instruction request
    output logic                 cop_insn_ack,  // Request acknowledge
    input  logic [31:0]          cpu_insn_enc,  // Encoded instruction
    input  logic [31:0]          cpu_rs1,       // GPR rs1 value
    output logic                 cop_wen,       // GPR write enable
    output logic [4:0]           cop_waddr,     // GPR write address
    output logic [31:0]          cop_wdata,     // GPR write data
    output cop_pkg::cop_result_e cop_result,    // Result code
    output logic                 cop_insn_rsp,  // Instruction finished
    output logic                 cop_mem_cen,   // Chip enable
    output logic                 cop_mem_wen,   // Write enable
    output logic [31:0]          cop_mem_addr,  // Word address
    output logic [31:0]          cop_mem_wdata, // Write data
    input  logic [31:0]          cop_mem_rdata, // Read data
    output logic [3:0]           cop_mem_ben,   // Byte enables
    input  logic                 cop_mem_stall, // Memory stall
    input  logic                 cop_mem_error  // Memory error
);

    import cop_pkg::*;

    cop_class_e  id_class;
    cop_op_e     id_op;
    logic [1:0]  id_pw;
    logic [3:0]  id_crs1, id_crs2, id_crd;
    logic [4:0]  id_rd;
    logic [2:0]  id_offset;
    logic        id_illegal;
    logic [31:0] crs1_rdata, crs2_rdata;             // CPR read data
    logic        crd_wen;
    logic [3:0]  crd_addr;
    logic [31:0] crd_wdata;
    logic        palu_ivalid, palu_idone, palu_cpr_wen;
    logic [31:0] palu_cpr_wdata, palu_gpr_wdata;
    logic        rng_ivalid, rng_idone, rng_cpr_wen;
    logic [31:0] rng_cpr_wdata;
    logic        mem_ivalid, mem_idone, mem_cpr_wen;
    logic        mem_is_store, mem_addr_error, mem_bus_error;
    logic [31:0] mem_cpr_wdata;

    cop_idecode u_idecode (
        .enc(cpu_insn_enc), .id_class, .id_op, .id_pw, .id_crs1, .id_crs2,
        .id_crd, .id_rd, .id_offset, .id_illegal
    );

    cop_cprs u_cprs (
        .g_clk, .rst_n,
        .rs1_addr(id_crs1), .rs1_rdata(crs1_rdata),
        .rs2_addr(id_crs2), .rs2_rdata(crs2_rdata),
        .rd_wen(crd_wen), .rd_addr(crd_addr), .rd_wdata(crd_wdata)
    );

    cop_palu u_palu (
        .ivalid(palu_ivalid), .idone(palu_idone), .op(id_op), .pw(id_pw),
        .gpr_rs1(cpu_rs1), .rs1(crs1_rdata), .rs2(crs2_rdata),
        .cpr_wen(palu_cpr_wen), .cpr_wdata(palu_cpr_wdata), .gpr_wdata(palu_gpr_wdata)
    );

    cop_rng u_rng (
        .g_clk, .rst_n, .ivalid(rng_ivalid), .idone(rng_idone), .op(id_op),
        .rs1(crs1_rdata), .cpr_wen(rng_cpr_wen), .cpr_wdata(rng_cpr_wdata)
    );

    cop_mem u_mem (
        .ivalid(mem_ivalid), .idone(mem_idone), .is_store(mem_is_store),
        .addr_error(mem_addr_error), .bus_error(mem_bus_error), .op(id_op),
        .gpr_rs1(cpu_rs1), .rs2(crs2_rdata), .offset(id_offset),
        .cpr_wen(mem_cpr_wen), .cpr_wdata(mem_cpr_wdata),
        .cop_mem_cen, .cop_mem_wen, .cop_mem_addr, .cop_mem_wdata,
        .cop_mem_rdata, .cop_mem_ben, .cop_mem_stall, .cop_mem_error
    );

    cop_fu_ctrl u_ctrl (
        .cpu_insn_req, .id_class, .id_op, .id_crd, .id_rd, .id_illegal,
        .palu_idone, .palu_cpr_wen, .palu_cpr_wdata, .palu_gpr_wdata,
        .rng_idone, .rng_cpr_wen, .rng_cpr_wdata,
        .mem_idone, .mem_cpr_wen, .mem_cpr_wdata,
        .mem_is_store, .mem_addr_error, .mem_bus_error,
        .palu_ivalid, .rng_ivalid, .mem_ivalid,
        .crd_wen, .crd_addr, .crd_wdata,
        .cop_insn_rsp, .cop_insn_ack, .cop_wen, .cop_waddr, .cop_wdata, .cop_result
    );

endmodule

`default_nettype wire

// File: src/cop_idecode.sv
/*
  Combinational decoder for the crypto instruction encoding.
  Splits out the register fields, maps the minor opcode to a unit class
  and flags anything the unit cannot execute as illegal.
*/
`timescale 1ns/10ps
`default_nettype none

module cop_idecode (
    input  logic [31:0]         enc,        // Encoded instruction
    output cop_pkg::cop_class_e id_class,   // Unit class
    output cop_pkg::cop_op_e    id_op,      // Minor opcode
    output logic [1:0]          id_pw,      // Pack width
    output logic [3:0]          id_crs1,    // CPR source 1
    output logic [3:0]          id_crs2,    // CPR source 2
    output logic [3:0]          id_crd,     // CPR destination
    output logic [4:0]          id_rd,      // GPR destination
    output logic [2:0]          id_offset,  // Word offset for loads/stores
    output logic                id_illegal  // Cannot execute
);

    import cop_pkg::*;

    logic major_ok; // Major opcode matches
    logic op_known; // Minor opcode is listed

    assign id_op     = cop_op_e'(enc[31:27]);
    assign id_pw     = enc[26:25];
    assign id_crs2   = enc[23:20];
    assign id_crs1   = enc[18:15];
    assign id_offset = enc[14:12];
    assign id_rd     = enc[11:7];
    assign id_crd    = enc[10:7];   // Overlaps rd on purpose

    assign major_ok  = (enc[6:0] == COP_OPCODE);

    always_comb begin
        op_known = 1'b1;
        case (id_op)
            OP_PADD, OP_PSUB, OP_XOR: id_class = CLASS_PALU;
            OP_GPR2XCR, OP_XCR2GPR:   id_class = CLASS_MOVE;
            OP_RSEED, OP_RSAMP:       id_class = CLASS_RNG;
            OP_LDW, OP_STW:           id_class = CLASS_MEM;
            default: begin
                id_class = CLASS_PALU; // Don't care, dispatch blocked
                op_known = 1'b0;
            end
        endcase
    end

    // Width 3 has no lane layout
    assign id_illegal = !major_ok || !op_known ||
                        ((id_op == OP_PADD || id_op == OP_PSUB) && id_pw == 2'd3);

endmodule

`default_nettype wire

// File: src/cop_mem.sv
/*
  Load/store unit for word-wide CPR accesses.
  Address is the GPR plus four times the word offset. Misaligned
  addresses complete at once without a bus access; aligned ones hold
  the request on the memory port until the stall drops.
*/
`timescale 1ns/10ps
`default_nettype none

module cop_mem (
    input  logic             ivalid,        // Instruction dispatched here
    output logic             idone,         // Instruction complete
    output logic             is_store,      // STW, not LDW
    output logic             addr_error,    // Misaligned address
    output logic             bus_error,     // Memory reported an error
    input  cop_pkg::cop_op_e op,            // Minor opcode
    input  logic [31:0]      gpr_rs1,       // Base address
    input  logic [31:0]      rs2,           // Store data from CPR source 2
    input  logic [2:0]       offset,        // Word offset
    output logic             cpr_wen,       // CPR write request
    output logic [31:0]      cpr_wdata,     // Load data, zero when idle
    output logic             cop_mem_cen,   // Chip enable
    output logic             cop_mem_wen,   // Write enable
    output logic [31:0]      cop_mem_addr,  // Word address
    output logic [31:0]      cop_mem_wdata, // Write data
    input  logic [31:0]      cop_mem_rdata, // Read data
    output logic [3:0]       cop_mem_ben,   // Byte enables
    input  logic             cop_mem_stall, // Access not finished yet
    input  logic             cop_mem_error  // Access failed
);

    import cop_pkg::*;

    logic [31:0] addr;     // Effective address
    logic        xfer_end; // Bus access completes this cycle

    assign addr       = gpr_rs1 + {27'd0, offset, 2'b00};
    assign is_store   = (op == OP_STW);
    assign addr_error = ivalid && (addr[1:0] != 2'b00);

    assign cop_mem_cen   = ivalid && !addr_error;
    assign cop_mem_wen   = cop_mem_cen && is_store;
    assign cop_mem_addr  = addr;
    assign cop_mem_wdata = rs2;
    assign cop_mem_ben   = 4'hF; // Word accesses only

    assign xfer_end  = cop_mem_cen && !cop_mem_stall;
    assign bus_error = xfer_end && cop_mem_error;
    assign idone     = addr_error || xfer_end;

    // Failed loads leave the CPR untouched
    assign cpr_wen   = xfer_end && !is_store && !cop_mem_error;
    assign cpr_wdata = cpr_wen ? cop_mem_rdata : '0;

endmodule

`default_nettype wire

// File: src/cop_palu.sv
/*
  Packed arithmetic and move unit, purely combinational.
  Add and subtract run per byte with the carry chain cut at the
  lane boundaries of the selected width. Completes in one cycle.
*/
`timescale 1ns/10ps
`default_nettype none

module cop_palu (
    input  logic             ivalid,    // Instruction dispatched here
    output logic             idone,     // Instruction complete
    input  cop_pkg::cop_op_e op,        // Minor opcode
    input  logic [1:0]       pw,        // Pack width
    input  logic [31:0]      gpr_rs1,   // GPR source from CPU
    input  logic [31:0]      rs1,       // CPR source 1
    input  logic [31:0]      rs2,       // CPR source 2
    output logic             cpr_wen,   // CPR write request
    output logic [31:0]      cpr_wdata, // CPR write data, zero when idle
    output logic [31:0]      gpr_wdata  // GPR result for XCR2GPR
);

    import cop_pkg::*;

    logic [31:0] arith;   // Packed add/sub result
    logic [31:0] result;  // Selected CPR result
    logic [3:0]  lane_lo; // Byte starts a new lane

    assign lane_lo = {pw == 2'd2, pw != 2'd0, pw == 2'd2, 1'b1};

    always_comb begin
        logic       sub;  // Subtract, B inverted with carry in
        logic       cy;   // Carry between bytes
        logic [7:0] b;    // Second operand byte
        logic [8:0] sum;  // Byte sum with carry out
        sub = (op == OP_PSUB);
        cy  = 1'b0;
        for (int i = 0; i < 4; i++) begin
            b   = sub ? ~rs2[8*i +: 8] : rs2[8*i +: 8];
            sum = {1'b0, rs1[8*i +: 8]} + {1'b0, b} + (lane_lo[i] ? sub : cy);
            arith[8*i +: 8] = sum[7:0];
            cy  = sum[8];
        end
    end

    always_comb begin
        case (op)
            OP_XOR:     result = rs1 ^ rs2;
            OP_GPR2XCR: result = gpr_rs1;
            default:    result = arith; // PADD and PSUB
        endcase
    end

    assign idone     = ivalid;
    assign cpr_wen   = ivalid && (op != OP_XCR2GPR);
    assign cpr_wdata = cpr_wen ? result : '0;
    assign gpr_wdata = (ivalid && op == OP_XCR2GPR) ? rs1 : '0;

endmodule

`default_nettype wire

// File: src/cop_pkg.sv
/*
  Shared definitions for the crypto ISE functional unit.
  Encoding: opcode [31:27], pack width [26:25], crs2 [23:20], crs1 [18:15],
  word offset [14:12], rd [11:7], crd [10:7], major opcode [6:0].
  Pack width 0 is one 32-bit lane, 1 is two 16-bit lanes, 2 is four
  8-bit lanes, and 3 is illegal for PADD/PSUB.
  Modules import what they need from here.
*/
`default_nettype none

package cop_pkg;

    localparam logic [6:0]  COP_OPCODE    = 7'h2B;        // Major opcode, enc[6:0]
    localparam int          COP_NUM_CPRS  = 16;           // Crypto register count
    localparam logic [31:0] COP_LFSR_TAPS = 32'hB4BCD35C; // Galois feedback mask
    localparam logic [31:0] COP_RNG_RESET = 32'h00000001; // LFSR reset and zero-seed value

    // Minor opcode from enc[31:27], other values are illegal
    typedef enum logic [4:0] {
        OP_PADD    = 5'h01, // Packed add
        OP_PSUB    = 5'h02, // Packed subtract
        OP_XOR     = 5'h03, // Bitwise XOR
        OP_GPR2XCR = 5'h04, // GPR to CPR move
        OP_XCR2GPR = 5'h05, // CPR to GPR move
        OP_RSEED   = 5'h06, // Seed the LFSR
        OP_RSAMP   = 5'h07, // Sample the LFSR
        OP_LDW     = 5'h08, // Load word to CPR
        OP_STW     = 5'h09  // Store word from CPR
    } cop_op_e;

    typedef enum logic [1:0] {
        CLASS_PALU = 2'd0, // Packed arithmetic and XOR
        CLASS_MOVE = 2'd1, // Register moves
        CLASS_RNG  = 2'd2, // Random source
        CLASS_MEM  = 2'd3  // Loads and stores
    } cop_class_e;

    typedef enum logic [2:0] {
        RES_SUCCESS = 3'd0, // Must stay zero
        RES_BAD_INS = 3'd1, // Illegal instruction
        RES_BAD_LAD = 3'd2, // Misaligned load
        RES_BAD_SAD = 3'd3, // Misaligned store
        RES_LD_ERR  = 3'd4, // Load bus error
        RES_ST_ERR  = 3'd5  // Store bus error
    } cop_result_e;

endpackage

`default_nettype wire

// File: src/cop_rng.sv
/*
  Random source built on a 32-bit Galois LFSR.
  RSEED loads a new state, RSAMP returns the state and steps once.
  The state moves on the edge that ends the response cycle.
*/
`timescale 1ns/10ps
`default_nettype none

module cop_rng (
    input  logic             g_clk,     // Clock
    input  logic             rst_n,     // Sync reset, active low
    input  logic             ivalid,    // Instruction dispatched here
    output logic             idone,     // Instruction complete
    input  cop_pkg::cop_op_e op,        // Minor opcode
    input  logic [31:0]      rs1,       // Seed from CPR source 1
    output logic             cpr_wen,   // CPR write request
    output logic [31:0]      cpr_wdata  // Sample, zero when idle
);

    import cop_pkg::*;

    logic [31:0] state;      // LFSR state
    logic [31:0] state_next; // One Galois step ahead

    assign state_next = {1'b0, state[31:1]} ^ (state[0] ? COP_LFSR_TAPS : 32'h0);

    always_ff @(posedge g_clk) begin
        if (!rst_n) begin
            state <= COP_RNG_RESET;
        end else if (ivalid && op == OP_RSEED) begin
            state <= (rs1 == '0) ? COP_RNG_RESET : rs1; // Zero would lock up
        end else if (ivalid && op == OP_RSAMP) begin
            state <= state_next;
        end
    end

    assign idone     = ivalid;
    assign cpr_wen   = ivalid && (op == OP_RSAMP);
    assign cpr_wdata = cpr_wen ? state : '0;

endmodule

`default_nettype wire

// File: test/tb_cop_fu.sv
/*
  Random-stimulus testbench for the crypto ISE functional unit.
  Holds each request like the CPU does, answers the memory port with
  random stalls and errors, and checks every response against a model
  of the CPRs, the LFSR and a 64-word memory.
*/
`timescale 1ns/10ps
`default_nettype none

module tb_cop_fu;

    import cop_pkg::*;

    localparam int N_ARITH = 40, N_RNG = 40, N_MEM = 48, N_ERR = 32, N_TIM = 16;
    localparam int N_INSNS = 34 + 2*N_ARITH + 2*N_RNG + 2*N_MEM + 2*N_ERR + N_TIM;
    localparam longint TIMEOUT_NS = (N_INSNS * 7 + 100) * 40; // 7 cycles worst per insn

    logic        g_clk = 1'b0, rst_n;
    logic        cpu_insn_req, cop_insn_ack, cop_insn_rsp, cop_wen;
    logic [31:0] cpu_insn_enc, cpu_rs1, cop_wdata;
    logic [4:0]  cop_waddr;
    cop_result_e cop_result;
    logic        cop_mem_cen, cop_mem_wen, cop_mem_stall, cop_mem_error;
    logic [31:0] cop_mem_addr, cop_mem_wdata, cop_mem_rdata;
    logic [3:0]  cop_mem_ben;

    logic [31:0] cpr_m [16];    // Model CPRs
    logic [31:0] lfsr_m;        // Model LFSR state
    logic [31:0] mem_words [64]; // Memory behind the port by addr[7:2]
    logic        saw_cen, cap_wen, cap_mem_wen;
    logic [4:0]  cap_waddr;
    logic [31:0] cap_wdata, cap_mem_addr, cap_mem_wdata;
    logic [3:0]  cap_ben;
    logic [2:0]  cap_result;
    int          cap_cycles;    // Cycles between request and response
    int          checks = 0, errors = 0, t_checks, t_errors;

    always #20 g_clk = ~g_clk;

    assign cop_mem_rdata = mem_words[cop_mem_addr[7:2]];

    cop_fu_top u_dut (
        .g_clk, .rst_n, .cpu_insn_req, .cop_insn_ack, .cpu_insn_enc, .cpu_rs1,
        .cop_wen, .cop_waddr, .cop_wdata, .cop_result, .cop_insn_rsp,
        .cop_mem_cen, .cop_mem_wen, .cop_mem_addr, .cop_mem_wdata,
        .cop_mem_rdata, .cop_mem_ben, .cop_mem_stall, .cop_mem_error
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp_v);
        checks++;
        assert (got === exp_v) else begin
            errors++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp_v);
        end
    endtask

    function automatic logic [31:0] encode(logic [4:0] op, logic [1:0] pw, logic [3:0] crs2,
                                           logic [3:0] crs1, logic [2:0] off, logic [4:0] rd);
        return {op, pw, 1'b0, crs2, 1'b0, crs1, off, rd, COP_OPCODE};
    endfunction

    function automatic bit insn_legal(logic [31:0] enc);
        logic [4:0] op;
        op = enc[31:27];
        return enc[6:0] == COP_OPCODE && op >= 5'd1 && op <= 5'd9 &&
               !((op == OP_PADD || op == OP_PSUB) && enc[26:25] == 2'd3);
    endfunction

    // Lane-wise add/sub with wrap inside each lane
    function automatic logic [31:0] lane_arith(logic [31:0] a, logic [31:0] b,
                                               logic [1:0] pw, bit sub);
        logic [31:0] r, mask, la, lb;
        int          w;
        w    = 32 >> pw;
        mask = (w == 32) ? 32'hFFFF_FFFF : ((32'h1 << w) - 1);
        r    = '0;
        for (int i = 0; i < 32 / w; i++) begin
            la = (a >> (i*w)) & mask;
            lb = (b >> (i*w)) & mask;
            r  = r | (((sub ? la - lb : la + lb) & mask) << (i*w));
        end
        return r;
    endfunction

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ COP_LFSR_TAPS) : (s >> 1);
    endfunction

    // Hold one request until the response as CPU and memory
    task automatic issue(input logic [31:0] enc, input logic [31:0] rs1,
                         input int stalls, input bit err);
        int left;
        bit done;
        bit legal;
        left = stalls;
        done = 0;
        saw_cen = 0;
        cap_cycles = 0;
        legal = insn_legal(enc);
        @(negedge g_clk);
        cpu_insn_req = 1'b1;
        cpu_insn_enc = enc;
        cpu_rs1 = rs1;
        cop_mem_stall = (left > 0);
        cop_mem_error = err;
        while (!done) begin
            #1;
            if (cop_mem_cen) saw_cen = 1'b1;
            if (cop_insn_rsp) begin
                done = 1;
                check_value("cop_insn_ack", cop_insn_ack, 1'b1);
                cap_wen = cop_wen;
                cap_waddr = cop_waddr;
                cap_wdata = cop_wdata;
                cap_result = cop_result;
                cap_mem_wen = cop_mem_wen;
                cap_mem_addr = cop_mem_addr;
                cap_mem_wdata = cop_mem_wdata;
                cap_ben = cop_mem_ben;
            end else begin
                check_value("cop_insn_ack", cop_insn_ack, 1'b0);
                @(negedge g_clk);
                cap_cycles++;
                if (left > 0) left--;
                cop_mem_stall = (left > 0);
            end
        end
        if (!(legal && (enc[31:27] == OP_LDW || enc[31:27] == OP_STW)))
            check_value("response latency", cap_cycles, 0); // Same-cycle reply
        if (!legal) check_value("cop_mem_cen", saw_cen, 1'b0);
        check_value("cop_wen", cap_wen, legal && enc[31:27] == OP_XCR2GPR);
        if (cap_wen) check_value("cop_waddr", cap_waddr, enc[11:7]);
        @(negedge g_clk);
        if (saw_cen && cap_mem_wen && !err) mem_words[cap_mem_addr[7:2]] = cap_mem_wdata;
        cpu_insn_req = 1'b0;
        cop_mem_stall = 1'b0;
        cop_mem_error = 1'b0;
        #1;
        check_value("idle cop_insn_rsp", cop_insn_rsp, 1'b0);
        check_value("idle cop_mem_cen", cop_mem_cen, 1'b0);
    endtask

    task automatic write_cpr(input logic [3:0] idx, input logic [31:0] v);
        issue(encode(OP_GPR2XCR, 0, 0, 0, 0, {1'b0, idx}), v, 0, 0);
        check_value("cop_result", cap_result, RES_SUCCESS);
        cpr_m[idx] = v;
    endtask

    task automatic check_cpr(input logic [3:0] idx);
        issue(encode(OP_XCR2GPR, 0, 0, idx, 0, 5'($urandom)), 0, 0, 0);
        check_value($sformatf("cpr[%0d]", idx), cap_wdata, cpr_m[idx]);
    endtask

    task automatic check_access(input logic [31:0] addr, input int stalls);
        check_value("cop_mem_cen", saw_cen, 1'b1);
        check_value("cop_mem_addr", cap_mem_addr, addr);
        check_value("cop_mem_ben", cap_ben, 4'hF);
        check_value("memory latency", cap_cycles, stalls); // Done on first free cycle
    endtask

    task automatic start_test();
        t_checks = checks;
        t_errors = errors;
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d checks, %0d errors", name, checks - t_checks, errors - t_errors);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the DUT did not finish the tests in the expected time");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] v, base, addr;
        logic [4:0]  op;
        logic [1:0]  pw;
        logic [3:0]  s1, s2, d;
        logic [2:0]  off;
        int          stalls, kind;
        bit          err;
        void'($urandom(32'h6563));
        cpu_insn_req = 1'b0;
        cpu_insn_enc = '0;
        cpu_rs1 = '0;
        cop_mem_stall = 1'b0;
        cop_mem_error = 1'b0;
        rst_n = 1'b0;
        for (int i = 0; i < 64; i++) mem_words[i] = 32'hC0DE0000 ^ (i * 32'h00010405);
        for (int i = 0; i < 16; i++) cpr_m[i] = '0;
        lfsr_m = COP_RNG_RESET;
        repeat (3) @(posedge g_clk);
        @(negedge g_clk);
        rst_n = 1'b1;

        start_test();
        #1;
        check_value("idle cop_insn_rsp", cop_insn_rsp, 1'b0);
        check_value("idle cop_mem_cen", cop_mem_cen, 1'b0);
        for (int i = 0; i < 16; i++) check_cpr(4'(i)); // All cleared
        issue(encode(OP_RSAMP, 0, 0, 0, 0, 5'd3), 0, 0, 0);
        check_value("cop_result", cap_result, RES_SUCCESS);
        cpr_m[3] = lfsr_m;
        lfsr_m = lfsr_step(lfsr_m);
        check_cpr(4'd3);
        check_value("first sample", cap_wdata, COP_RNG_RESET);
        end_test("reset");

        start_test();
        for (int i = 0; i < 16; i++) write_cpr(4'(i), $urandom);
        repeat (N_ARITH) begin
            case ($urandom % 3)
                0:       op = OP_PADD;
                1:       op = OP_PSUB;
                default: op = OP_XOR;
            endcase
            pw = 2'($urandom % 3);
            s1 = 4'($urandom);
            s2 = 4'($urandom);
            d = 4'($urandom);
            issue(encode(op, pw, s2, s1, 0, {1'($urandom), d}), $urandom, 0, 0);
            check_value("cop_result", cap_result, RES_SUCCESS);
            cpr_m[d] = (op == OP_XOR) ? cpr_m[s1] ^ cpr_m[s2] :
                       lane_arith(cpr_m[s1], cpr_m[s2], pw, op == OP_PSUB);
            check_cpr(d);
        end
        end_test("packed arithmetic");

        start_test();
        repeat (N_RNG) begin
            if ($urandom % 3 == 0) begin
                v  = ($urandom % 4 == 0) ? 32'h0 : $urandom; // Zero seeds too
                s1 = 4'($urandom);
                write_cpr(s1, v);
                issue(encode(OP_RSEED, 0, 0, s1, 0, 5'($urandom)), 0, 0, 0);
                check_value("cop_result", cap_result, RES_SUCCESS);
                lfsr_m = (v == 0) ? COP_RNG_RESET : v;
            end else begin
                d = 4'($urandom);
                issue(encode(OP_RSAMP, 0, 0, 0, 0, {1'b0, d}), 0, 0, 0);
                check_value("cop_result", cap_result, RES_SUCCESS);
                cpr_m[d] = lfsr_m;
                lfsr_m = lfsr_step(lfsr_m);
                check_cpr(d);
            end
        end
        end_test("random unit");

        start_test();
        repeat (N_MEM) begin
            base = ($urandom % 64) * 4;
            off = 3'($urandom);
            addr = base + 32'(off) * 4;
            stalls = $urandom % 4;
            err = ($urandom % 8 == 0);
            s2 = 4'($urandom);
            d = 4'($urandom);
            if ($urandom % 2) begin
                v = $urandom;
                write_cpr(s2, v);
                issue(encode(OP_STW, 0, s2, 0, off, 5'($urandom)), base, stalls, err);
                check_access(addr, stalls);
                check_value("cop_mem_wen", cap_mem_wen, 1'b1);
                check_value("cop_mem_wdata", cap_mem_wdata, v);
                check_value("cop_result", cap_result, err ? RES_ST_ERR : RES_SUCCESS);
            end else begin
                v = mem_words[addr[7:2]];
                issue(encode(OP_LDW, 0, 0, 0, off, {1'b0, d}), base, stalls, err);
                check_access(addr, stalls);
                check_value("cop_mem_wen", cap_mem_wen, 1'b0);
                check_value("cop_result", cap_result, err ? RES_LD_ERR : RES_SUCCESS);
                if (!err) cpr_m[d] = v; // Bus error keeps old value
                check_cpr(d);
            end
        end
        end_test("load/store");

        start_test();
        repeat (N_ERR) begin
            d = 4'($urandom);
            kind = $urandom % 4;
            if (kind == 0) begin
                base = ($urandom & 32'hFFFF_FFFC) | (1 + $urandom % 3);
                op = ($urandom % 2) ? OP_STW : OP_LDW;
                issue(encode(op, 0, d, 0, 3'($urandom), {1'b0, d}), base, $urandom % 4, 0);
                check_value("cop_mem_cen", saw_cen, 1'b0);
                check_value("response latency", cap_cycles, 0); // Stall is ignored
                check_value("cop_result", cap_result,
                            (op == OP_STW) ? RES_BAD_SAD : RES_BAD_LAD);
            end else begin
                case (kind)
                    1:       op = 5'(1 + $urandom % 9);                        // Bad major
                    2:       op = ($urandom % 2) ? 5'd0 : 5'(10 + $urandom % 22); // Unlisted
                    default: op = ($urandom % 2) ? OP_PSUB : OP_PADD;
                endcase
                v = encode(op, (kind == 3) ? 2'd3 : 2'd0, d, d, 0, {1'b0, d});
                if (kind == 1) v = v ^ 32'(1 + $urandom % 127);
                issue(v, $urandom, 0, 0);
                check_value("cop_result", cap_result, RES_BAD_INS);
            end
            check_cpr(d);
        end
        end_test("errors");

        start_test();
        repeat (N_TIM) begin
            s1 = 4'($urandom);
            issue(encode(OP_XCR2GPR, 0, 0, s1, 0, 5'($urandom)), $urandom, 0, 0);
            check_value("cop_wdata", cap_wdata, cpr_m[s1]);
        end
        end_test("response timing");

        $display("totals: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
